//--- include/hsi_defs.svh
`ifndef HSI_DEFS_SVH
`define HSI_DEFS_SVH

`define HSI_TM_LEN 8 // frame body lengths in bytes without the CRC.
`define HSI_SR_LEN 4
`define HSI_CCW_LEN 3

`define HSI_TM_HDR 8'hA1
`define HSI_BTC_HDR 8'hB2
`define HSI_SR_HDR 8'hC3

`define HSI_GUARD_TICKS 400 // clk cycles of silence after every frame.
`define HSI_BTC_PER_TM 3

`endif

//--- verilog/hsi_pkg.sv
package hsi_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] crc_t;
	typedef logic [39:0] btc_t; // on-board time code.

	typedef enum logic [2:0] {
		st_idle,
		st_send_tm,
		st_send_btc,
		st_send_sr,
		st_send_ccw,
		st_send_crc,
		st_guard
	} tx_state_t;

	typedef enum logic [2:0] {src_none, src_tm, src_btc, src_sr, src_ccw, src_crc} src_t;

endpackage

//--- verilog/hsi_byte_if.sv
interface hsi_byte_if;
	import hsi_pkg::*;

	byte_t d;
	logic d_rdy; // one clk wide and never two in a row.
	logic msg_end; // comes with the d_rdy of the last byte.
	logic grant;
	logic cd_busy;

	modport src (output d, output d_rdy, output msg_end, input grant, input cd_busy);

	modport arb (input d, input d_rdy, input msg_end, output grant, output cd_busy);

endinterface

//--- verilog/hsi_m_tx_ctrl.sv
`include "hsi_defs.svh"

module hsi_m_tx_ctrl (
	input logic clk,
	input logic n_rst,
	input logic tm_tx_rdy,
	input logic sr_tx_rdy,
	input logic ccw_tx_rdy,
	input logic pre_tm,
	input logic tm_en,
	input logic sdreq_en,
	input logic btc_en,
	input logic btc_due,
	input logic cd_busy,
	hsi_byte_if.arb tm_sr_bus,
	hsi_byte_if.arb btc_bus,
	hsi_byte_if.arb ccw_bus,
	hsi_byte_if.arb crc_bus,
	output logic sel_sr,
	output hsi_pkg::byte_t d_out,
	output logic d_rdy_out,
	output logic tm_tx_ack,
	output logic sr_tx_ack,
	output logic crc_clear,
	output logic [1:0] reply_wait,
	output logic frame_to_reply_end
);
	import hsi_pkg::*;

	localparam int GUARD_W = $clog2(`HSI_GUARD_TICKS);

	tx_state_t state, state_nxt;
	src_t owner;
	logic [GUARD_W-1:0] guard_cnt;
	logic guard_done;
	logic [1:0] reply_kind; // bit 0 service request, bit 1 command word.
	logic tm_req, btc_req, sr_req, ccw_req;

	assign tm_req = tm_en & tm_tx_rdy;
	assign btc_req = btc_en & btc_due;
	assign sr_req = sdreq_en & sr_tx_rdy;
	assign ccw_req = ~pre_tm & ccw_tx_rdy; // command words wait while telemetry is imminent.
	assign guard_done = (guard_cnt == GUARD_W'(`HSI_GUARD_TICKS - 1));

	always_comb
	begin
		state_nxt = state;
		case (state)
			st_idle:
			begin
				if (tm_req)
					state_nxt = st_send_tm;
				else if (btc_req)
					state_nxt = st_send_btc;
				else if (sr_req)
					state_nxt = st_send_sr;
				else if (ccw_req)
					state_nxt = st_send_ccw;
			end
			st_send_tm, st_send_sr:
				if (tm_sr_bus.msg_end)
					state_nxt = st_send_crc;
			st_send_btc:
				if (btc_bus.msg_end)
					state_nxt = st_send_crc;
			st_send_ccw:
				if (ccw_bus.msg_end)
					state_nxt = st_send_crc;
			st_send_crc:
				if (crc_bus.msg_end)
					state_nxt = st_guard;
			st_guard:
				if (guard_done)
					state_nxt = st_idle;
			default:
				state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			state <= st_idle;
			guard_cnt <= '0;
			reply_kind <= 2'b00;
		end
		else
		begin
			state <= state_nxt;
			if (state == st_guard && !guard_done)
				guard_cnt <= guard_cnt + 1'b1;
			else
				guard_cnt <= '0;
			// the kind of frame is fixed when it is granted and kept through the guard.
			if (state == st_idle)
				reply_kind <= {state_nxt == st_send_ccw, state_nxt == st_send_sr};
		end
	end

	always_comb
	begin
		case (state)
			st_send_tm: owner = src_tm;
			st_send_btc: owner = src_btc;
			st_send_sr: owner = src_sr;
			st_send_ccw: owner = src_ccw;
			st_send_crc: owner = src_crc;
			default: owner = src_none;
		endcase
	end

	assign tm_sr_bus.grant = (owner == src_tm) | (owner == src_sr);
	assign btc_bus.grant = (owner == src_btc);
	assign ccw_bus.grant = (owner == src_ccw);
	assign crc_bus.grant = (owner == src_crc);
	assign tm_sr_bus.cd_busy = cd_busy;
	assign btc_bus.cd_busy = cd_busy;
	assign ccw_bus.cd_busy = cd_busy;
	assign crc_bus.cd_busy = cd_busy;

	always_comb
	begin
		d_out = '0;
		d_rdy_out = 1'b0;
		case (owner)
			src_tm, src_sr:
			begin
				d_out = tm_sr_bus.d;
				d_rdy_out = tm_sr_bus.d_rdy;
			end
			src_btc:
			begin
				d_out = btc_bus.d;
				d_rdy_out = btc_bus.d_rdy;
			end
			src_ccw:
			begin
				d_out = ccw_bus.d;
				d_rdy_out = ccw_bus.d_rdy;
			end
			src_crc:
			begin
				d_out = crc_bus.d;
				d_rdy_out = crc_bus.d_rdy;
			end
			default: ;
		endcase
	end

	assign sel_sr = (state == st_send_sr);
	assign tm_tx_ack = (state == st_send_tm);
	assign sr_tx_ack = sel_sr;
	assign crc_clear = (state == st_idle);
	assign reply_wait = (state == st_guard) ? reply_kind : 2'b00;
	assign frame_to_reply_end = (state == st_send_crc) & crc_bus.msg_end & (|reply_kind);

endmodule

//--- verilog/hsi_frame_src.sv
`include "hsi_defs.svh"

module hsi_frame_src (
	input logic clk,
	input logic n_rst,
	input logic sel_sr,
	hsi_byte_if.src bus,
	output logic tm_done
);
	import hsi_pkg::*;

	byte_t idx, last_idx;
	byte_t tm_seq, sr_seq;

	assign last_idx = sel_sr ? byte_t'(`HSI_SR_LEN - 1) : byte_t'(`HSI_TM_LEN - 1);
	assign bus.d_rdy = bus.grant & ~bus.cd_busy; // the frame body is always ready.
	assign bus.msg_end = bus.d_rdy & (idx == last_idx);
	assign tm_done = bus.msg_end & ~sel_sr;

	always_comb
	begin
		if (idx == 8'd0)
			bus.d = sel_sr ? `HSI_SR_HDR : `HSI_TM_HDR;
		else if (idx == 8'd1)
			bus.d = sel_sr ? sr_seq : tm_seq;
		else
			bus.d = idx; // fill bytes carry their own position.
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			idx <= '0;
			tm_seq <= '0;
			sr_seq <= '0;
		end
		else if (bus.msg_end)
		begin
			idx <= '0;
			if (sel_sr)
				sr_seq <= sr_seq + 1'b1;
			else
				tm_seq <= tm_seq + 1'b1;
		end
		else if (bus.d_rdy)
			idx <= idx + 1'b1;
	end

endmodule

//--- verilog/hsi_btc_src.sv
`include "hsi_defs.svh"

module hsi_btc_src (
	input logic clk,
	input logic n_rst,
	input hsi_pkg::btc_t btc,
	input logic tm_done,
	output logic btc_due,
	hsi_byte_if.src bus
);
	import hsi_pkg::*;

	localparam int BTC_BYTES = $bits(btc_t) / 8;
	localparam int CNT_W = $clog2(`HSI_BTC_PER_TM);

	logic [CNT_W-1:0] tm_cnt;
	logic [2:0] idx;
	logic active; // set one cycle after the grant, once btc is latched.
	btc_t btc_sh;

	assign bus.d = (idx == 3'd0) ? `HSI_BTC_HDR : btc_sh[7:0];
	assign bus.d_rdy = bus.grant & active & ~bus.cd_busy;
	assign bus.msg_end = bus.d_rdy & (idx == 3'(BTC_BYTES));

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			tm_cnt <= '0;
			btc_due <= 1'b0;
		end
		else if (tm_done)
		begin
			if (tm_cnt == CNT_W'(`HSI_BTC_PER_TM - 1))
			begin
				tm_cnt <= '0;
				btc_due <= 1'b1;
			end
			else
				tm_cnt <= tm_cnt + 1'b1;
		end
		else if (bus.grant)
			btc_due <= 1'b0;
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			active <= 1'b0;
			idx <= '0;
		end
		else if (bus.msg_end)
		begin
			active <= 1'b0;
			idx <= '0;
		end
		else
		begin
			if (bus.grant)
				active <= 1'b1;
			if (bus.d_rdy)
				idx <= idx + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus.grant && !active)
			btc_sh <= btc;
		else if (bus.d_rdy && idx != 3'd0)
			btc_sh <= btc_sh >> 8; // least significant byte goes first.
	end

endmodule

//--- verilog/hsi_ccw_src.sv
`include "hsi_defs.svh"

module hsi_ccw_src (
	input logic clk,
	input logic n_rst,
	input hsi_pkg::byte_t ccw_d,
	input logic ccw_d_rdy,
	output logic ccw_tx_en,
	output logic ccw_d_sending,
	hsi_byte_if.src bus
);
	import hsi_pkg::*;

	localparam int CNT_W = $clog2(`HSI_CCW_LEN);

	byte_t hold;
	logic pending; // a byte was taken from outside and has not reached the coder yet.
	logic in_coder; // the coder is busy with a byte of ours.
	logic [CNT_W-1:0] cnt;

	assign ccw_tx_en = bus.grant;
	// the outside source waits for this to fall before the next strobe.
	assign ccw_d_sending = pending | (in_coder & bus.cd_busy);
	assign bus.d = hold;
	assign bus.d_rdy = bus.grant & pending & ~bus.cd_busy;
	assign bus.msg_end = bus.d_rdy & (cnt == CNT_W'(`HSI_CCW_LEN - 1));

	always_ff @(posedge clk)
	begin
		if (bus.grant && ccw_d_rdy)
			hold <= ccw_d;
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			pending <= 1'b0;
			in_coder <= 1'b0;
			cnt <= '0;
		end
		else
		begin
			if (bus.grant && ccw_d_rdy)
				pending <= 1'b1;
			else if (bus.d_rdy)
				pending <= 1'b0;
			if (bus.d_rdy)
				in_coder <= 1'b1;
			else if (!bus.cd_busy)
				in_coder <= 1'b0;
			if (bus.msg_end)
				cnt <= '0;
			else if (bus.d_rdy)
				cnt <= cnt + 1'b1;
		end
	end

endmodule

//--- verilog/hsi_crc_unit.sv
module hsi_crc_unit (
	input logic clk,
	input logic n_rst,
	input logic crc_clear,
	input hsi_pkg::byte_t d,
	input logic d_rdy,
	hsi_byte_if.src bus
);
	import hsi_pkg::*;

	localparam crc_t POLY = 16'h1021;
	localparam crc_t INIT = 16'hFFFF;

	crc_t crc;
	logic hi_sent;

	// one byte of CRC-16/CCITT taken MSB first.
	function automatic crc_t crc_step(input crc_t c, input byte_t b);
		crc_t r;
		r = c;
		for (int i = 7; i >= 0; i--)
		begin
			if (r[15] ^ b[i])
				r = {r[14:0], 1'b0} ^ POLY;
			else
				r = {r[14:0], 1'b0};
		end
		return r;
	endfunction

	assign bus.d = hi_sent ? crc[7:0] : crc[15:8];
	assign bus.d_rdy = bus.grant & ~bus.cd_busy;
	assign bus.msg_end = bus.d_rdy & hi_sent;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			crc <= INIT;
			hi_sent <= 1'b0;
		end
		else
		begin
			if (crc_clear)
				crc <= INIT;
			else if (d_rdy && !bus.grant) // our own bytes are not folded in.
				crc <= crc_step(crc, d);
			if (bus.msg_end)
				hi_sent <= 1'b0;
			else if (bus.d_rdy)
				hi_sent <= 1'b1;
		end
	end

endmodule

//--- verilog/hsi_coder.sv
module hsi_coder (
	input logic clk,
	input logic n_rst,
	input logic clk_en,
	input hsi_pkg::byte_t d,
	input logic d_rdy,
	output logic busy,
	output logic q
);
	logic [9:0] shreg;
	logic [3:0] cnt; // bits still to put on the line.

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			busy <= 1'b0;
			cnt <= '0;
			q <= 1'b1; // idle line.
		end
		else if (d_rdy)
		begin
			busy <= 1'b1;
			cnt <= 4'd10;
		end
		else if (clk_en && busy)
		begin
			if (cnt != 4'd0)
			begin
				q <= shreg[0];
				cnt <= cnt - 1'b1;
			end
			else
				busy <= 1'b0; // the stop bit has had its full tick.
		end
	end

	always_ff @(posedge clk)
	begin
		if (d_rdy)
			shreg <= {1'b1, d, 1'b0}; // stop, data LSB first, start.
		else if (clk_en && busy && cnt != 4'd0)
			shreg <= {1'b1, shreg[9:1]};
	end

endmodule

//--- verilog/hsi_m_tx.sv
module hsi_m_tx (
	input logic clk,
	input logic n_rst,
	input logic clk_en,
	input logic tm_en,
	input logic tm_tx_rdy,
	output logic tm_tx_ack,
	input logic sdreq_en,
	input logic sr_tx_rdy,
	output logic sr_tx_ack,
	input logic pre_tm,
	input logic btc_en,
	input hsi_pkg::btc_t btc,
	input hsi_pkg::byte_t ccw_d,
	input logic ccw_tx_rdy,
	input logic ccw_d_rdy,
	output logic ccw_tx_en,
	output logic ccw_d_sending,
	output logic cd_q,
	output logic [1:0] reply_wait,
	output logic frame_to_reply_end
);
	import hsi_pkg::*;

	byte_t d_mux;
	logic d_rdy_mux;
	logic cd_busy;
	logic sel_sr;
	logic tm_done;
	logic btc_due;
	logic crc_clear;

	hsi_byte_if tm_sr_bus ();
	hsi_byte_if btc_bus ();
	hsi_byte_if ccw_bus ();
	hsi_byte_if crc_bus ();

	hsi_m_tx_ctrl ctrl0 (
		.clk(clk),
		.n_rst(n_rst),
		.tm_tx_rdy(tm_tx_rdy),
		.sr_tx_rdy(sr_tx_rdy),
		.ccw_tx_rdy(ccw_tx_rdy),
		.pre_tm(pre_tm),
		.tm_en(tm_en),
		.sdreq_en(sdreq_en),
		.btc_en(btc_en),
		.btc_due(btc_due),
		.cd_busy(cd_busy),
		.tm_sr_bus(tm_sr_bus.arb),
		.btc_bus(btc_bus.arb),
		.ccw_bus(ccw_bus.arb),
		.crc_bus(crc_bus.arb),
		.sel_sr(sel_sr),
		.d_out(d_mux),
		.d_rdy_out(d_rdy_mux),
		.tm_tx_ack(tm_tx_ack),
		.sr_tx_ack(sr_tx_ack),
		.crc_clear(crc_clear),
		.reply_wait(reply_wait),
		.frame_to_reply_end(frame_to_reply_end)
	);

	hsi_frame_src frame0 (
		.clk(clk),
		.n_rst(n_rst),
		.sel_sr(sel_sr),
		.bus(tm_sr_bus.src),
		.tm_done(tm_done)
	);

	hsi_btc_src btc0 (
		.clk(clk),
		.n_rst(n_rst),
		.btc(btc),
		.tm_done(tm_done),
		.btc_due(btc_due),
		.bus(btc_bus.src)
	);

	hsi_ccw_src ccw0 (
		.clk(clk),
		.n_rst(n_rst),
		.ccw_d(ccw_d),
		.ccw_d_rdy(ccw_d_rdy),
		.ccw_tx_en(ccw_tx_en),
		.ccw_d_sending(ccw_d_sending),
		.bus(ccw_bus.src)
	);

	hsi_crc_unit crc0 (
		.clk(clk),
		.n_rst(n_rst),
		.crc_clear(crc_clear),
		.d(d_mux),
		.d_rdy(d_rdy_mux),
		.bus(crc_bus.src)
	);

	hsi_coder coder0 (
		.clk(clk),
		.n_rst(n_rst),
		.clk_en(clk_en),
		.d(d_mux),
		.d_rdy(d_rdy_mux),
		.busy(cd_busy),
		.q(cd_q)
	);

endmodule

//--- test/hsi_m_tx_tb.sv
`include "hsi_defs.svh"

module hsi_m_tx_tb;
	localparam int TIMEOUT = 5000; // clk cycles allowed for any single wait.
	localparam int N_ROWS = 6;
	localparam logic [3:0] K_NONE = 4'd0;
	localparam logic [3:0] K_TM = 4'd1;
	localparam logic [3:0] K_BTC = 4'd2;
	localparam logic [3:0] K_SR = 4'd3;
	localparam logic [3:0] K_CCW = 4'd4;

	typedef struct packed {
		logic tm;
		logic sr;
		logic ccw;
		logic pre;
		logic [39:0] btc;
		logic [23:0] ccw_bytes; // the first byte on the line sits in the top eight bits.
		logic [3:0] kind0;
		logic [3:0] kind1;
		logic [3:0] kind2;
	} row_t;

	logic clk, n_rst;
	logic clk_en = 1'b0;
	logic tm_en, tm_tx_rdy, tm_tx_ack;
	logic sdreq_en, sr_tx_rdy, sr_tx_ack;
	logic pre_tm, btc_en;
	logic [39:0] btc;
	logic [7:0] ccw_d;
	logic ccw_tx_rdy, ccw_d_rdy, ccw_tx_en, ccw_d_sending;
	logic cd_q;
	logic [1:0] reply_wait;
	logic frame_to_reply_end;

	row_t rows [N_ROWS];
	logic [7:0] rx_q [$];
	logic [7:0] exp_q [$];
	logic [7:0] rx_sh;
	logic [1:0] en_cnt = 2'd0;
	int rx_bit = -1;
	int frame_errs = 0;
	int n_ftre = 0, n_rw0 = 0, n_rw1 = 0, n_tm_ack = 0, n_sr_ack = 0, n_ccw_snd = 0;
	int errors, rx_rd;
	bit timed_out;
	logic [7:0] tm_seq_m, sr_seq_m;
	logic [15:0] crc_acc;

	hsi_m_tx dut0 (
		.clk(clk), .n_rst(n_rst), .clk_en(clk_en),
		.tm_en(tm_en), .tm_tx_rdy(tm_tx_rdy), .tm_tx_ack(tm_tx_ack),
		.sdreq_en(sdreq_en), .sr_tx_rdy(sr_tx_rdy), .sr_tx_ack(sr_tx_ack),
		.pre_tm(pre_tm), .btc_en(btc_en), .btc(btc),
		.ccw_d(ccw_d), .ccw_tx_rdy(ccw_tx_rdy), .ccw_d_rdy(ccw_d_rdy),
		.ccw_tx_en(ccw_tx_en), .ccw_d_sending(ccw_d_sending),
		.cd_q(cd_q), .reply_wait(reply_wait), .frame_to_reply_end(frame_to_reply_end)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// clk_en is high one cycle in four. The bit a tick puts on cd_q is read at the next
	// falling edge, before clk_en moves on.
	always @(negedge clk)
	begin
		if (!n_rst)
			rx_bit = -1;
		else if (clk_en)
		begin
			if (rx_bit < 0)
			begin
				if (cd_q == 1'b0)
					rx_bit = 0; // start bit.
			end
			else if (rx_bit < 8)
			begin
				rx_sh = {cd_q, rx_sh[7:1]};
				rx_bit++;
			end
			else
			begin
				if (cd_q != 1'b1)
				begin
					$display("Framing error at %0t: the stop bit on cd_q is low", $time);
					frame_errs++;
				end
				rx_q.push_back(rx_sh);
				rx_bit = -1;
			end
		end
		en_cnt = en_cnt + 2'd1;
		clk_en = (en_cnt == 2'd3);
	end

	always @(negedge clk)
	begin
		if (n_rst)
		begin
			if (frame_to_reply_end)
				n_ftre++;
			if (reply_wait[0])
				n_rw0++;
			if (reply_wait[1])
				n_rw1++;
			if (tm_tx_ack)
				n_tm_ack++;
			if (sr_tx_ack)
				n_sr_ack++;
			if (ccw_d_sending)
				n_ccw_snd++;
		end
	end

	// reference CRC-16/CCITT that takes a whole byte per call.
	function automatic logic [15:0] crc_ref(input logic [15:0] crc, input logic [7:0] b);
		logic [15:0] c;
		c = crc ^ {b, 8'h00};
		repeat (8)
			c = c[15] ? ((c << 1) ^ 16'h1021) : (c << 1);
		return c;
	endfunction

	function automatic logic ack_of(input logic [3:0] kind);
		case (kind)
			K_TM: return tm_tx_ack;
			K_SR: return sr_tx_ack;
			K_CCW: return ccw_tx_en;
			default: return 1'b1; // the time code has no acknowledge.
		endcase
	endfunction

	task automatic add_byte(input logic [7:0] b);
		exp_q.push_back(b);
		crc_acc = crc_ref(crc_acc, b);
	endtask

	task automatic build_frame(input logic [3:0] kind, input logic [39:0] tc,
		input logic [23:0] cw);
		logic [39:0] t;
		logic [23:0] w;
		t = tc;
		w = cw;
		crc_acc = 16'hFFFF;
		case (kind)
			K_TM:
			begin
				add_byte(`HSI_TM_HDR);
				add_byte(tm_seq_m);
				for (int i = 2; i < `HSI_TM_LEN; i++)
					add_byte(8'(i));
			end
			K_SR:
			begin
				add_byte(`HSI_SR_HDR);
				add_byte(sr_seq_m);
				for (int i = 2; i < `HSI_SR_LEN; i++)
					add_byte(8'(i));
			end
			K_BTC:
			begin
				add_byte(`HSI_BTC_HDR);
				repeat (5)
				begin
					add_byte(t[7:0]);
					t = t >> 8;
				end
			end
			default:
				repeat (`HSI_CCW_LEN)
				begin
					add_byte(w[23:16]);
					w = w << 8;
				end
		endcase
		exp_q.push_back(crc_acc[15:8]);
		exp_q.push_back(crc_acc[7:0]);
	endtask

	task automatic wait_grant(input logic [3:0] kind);
		int t;
		t = 0;
		while (!timed_out && !ack_of(kind))
		begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
			begin
				$display("Timeout at %0t: frame kind %0d was never granted", $time, kind);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic feed_ccw(input logic [23:0] cw);
		logic [23:0] w;
		int t;
		w = cw;
		repeat (`HSI_CCW_LEN)
		begin
			t = 0;
			while (!timed_out && ccw_d_sending)
			begin
				@(negedge clk);
				t++;
				if (t > TIMEOUT)
				begin
					$display("Timeout at %0t: ccw_d_sending never fell", $time);
					timed_out = 1'b1;
				end
			end
			if (!timed_out)
			begin
				ccw_d = w[23:16];
				ccw_d_rdy = 1'b1;
				@(negedge clk);
				ccw_d_rdy = 1'b0;
				w = w << 8;
			end
		end
	endtask

	task automatic check_frame(input logic [3:0] kind);
		int t;
		logic [7:0] got;
		t = 0;
		while (!timed_out && rx_q.size() < rx_rd + exp_q.size())
		begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
			begin
				$display("Timeout at %0t: frame kind %0d is incomplete on cd_q", $time, kind);
				timed_out = 1'b1;
			end
		end
		for (int pos = 0; !timed_out && pos < exp_q.size(); pos++)
		begin
			got = rx_q[rx_rd];
			rx_rd++;
			if (got !== exp_q[pos])
			begin
				$display("Error at %0t: cd_q byte %0d of frame kind %0d expected %h, got %h",
					$time, pos, kind, exp_q[pos], got);
				errors++;
			end
		end
		exp_q.delete();
	endtask

	initial
	begin
		int row_err, tests, failed, held, n_tm, n_sr, n_ccw;
		int ftre0, rw00, rw10, tma0, sra0, ccs0;
		logic [3:0] kinds [3];
		n_rst = 1'b0;
		tm_en = 1'b1;
		tm_tx_rdy = 1'b0;
		sdreq_en = 1'b1;
		sr_tx_rdy = 1'b0;
		pre_tm = 1'b0;
		btc_en = 1'b1;
		btc = '0;
		ccw_d = '0;
		ccw_tx_rdy = 1'b0;
		ccw_d_rdy = 1'b0;
		errors = 0;
		rx_rd = 0;
		timed_out = 1'b0;
		tests = 1;
		failed = 0;
		tm_seq_m = 8'd0;
		sr_seq_m = 8'd0;

		//        tm    sr    ccw   pre   btc              ccw bytes    frame kinds in order
		rows[0] = {1'b1, 1'b0, 1'b0, 1'b0, 40'h0, 24'h0, K_TM, K_NONE, K_NONE};
		rows[1] = {1'b1, 1'b0, 1'b0, 1'b0, 40'h0, 24'h0, K_TM, K_NONE, K_NONE};
		rows[2] = {1'b1, 1'b0, 1'b0, 1'b0, 40'h12_3456_789A, 24'h0, K_TM, K_BTC, K_NONE};
		rows[3] = {1'b1, 1'b1, 1'b0, 1'b0, 40'h0, 24'h0, K_TM, K_SR, K_NONE};
		rows[4] = {1'b0, 1'b1, 1'b0, 1'b0, 40'h0, 24'h0, K_SR, K_NONE, K_NONE};
		rows[5] = {1'b0, 1'b0, 1'b1, 1'b1, 40'h0, 24'h5A_0FE7, K_CCW, K_NONE, K_NONE};

		repeat (16) @(negedge clk);
		if ({cd_q, tm_tx_ack, sr_tx_ack, ccw_tx_en, reply_wait, frame_to_reply_end} !== 7'b1000000)
		begin
			$display("Error at %0t: {cd_q, acks, ccw_tx_en, reply_wait, frame_to_reply_end}",
				$time);
			$display("  expected 1000000, got %b", {cd_q, tm_tx_ack, sr_tx_ack, ccw_tx_en,
				reply_wait, frame_to_reply_end});
			errors++;
			failed++;
		end
		$display("reset: %s", (errors == 0) ? "pass" : "FAIL");
		n_rst = 1'b1;
		repeat (4) @(negedge clk);

		for (int r = 0; r < N_ROWS && !timed_out; r++)
		begin
			row_err = errors;
			tests++;
			kinds[0] = rows[r].kind0;
			kinds[1] = rows[r].kind1;
			kinds[2] = rows[r].kind2;
			n_tm = 0;
			n_sr = 0;
			n_ccw = 0;
			for (int k = 0; k < 3; k++)
			begin
				if (kinds[k] == K_TM)
					n_tm++;
				if (kinds[k] == K_SR)
					n_sr++;
				if (kinds[k] == K_CCW)
					n_ccw++;
			end
			ftre0 = n_ftre;
			rw00 = n_rw0;
			rw10 = n_rw1;
			tma0 = n_tm_ack;
			sra0 = n_sr_ack;
			ccs0 = n_ccw_snd;
			tm_tx_rdy = rows[r].tm;
			sr_tx_rdy = rows[r].sr;
			ccw_tx_rdy = rows[r].ccw;
			pre_tm = rows[r].pre;
			btc = rows[r].btc;

			if (rows[r].pre)
			begin
				held = 0;
				repeat (100)
				begin
					@(negedge clk);
					if (ccw_tx_en)
						held++;
				end
				if (held != 0)
				begin
					$display("Error at %0t: ccw_tx_en expected 0, got 1 while pre_tm was high",
						$time);
					errors++;
				end
				pre_tm = 1'b0;
			end

			for (int k = 0; k < 3; k++)
			begin
				if (kinds[k] != K_NONE && !timed_out)
				begin
					build_frame(kinds[k], rows[r].btc, rows[r].ccw_bytes);
					wait_grant(kinds[k]);
					if (kinds[k] == K_TM)
						tm_tx_rdy = 1'b0;
					else if (kinds[k] == K_SR)
						sr_tx_rdy = 1'b0;
					else if (kinds[k] == K_CCW)
					begin
						ccw_tx_rdy = 1'b0;
						feed_ccw(rows[r].ccw_bytes);
					end
					check_frame(kinds[k]);
					if (kinds[k] == K_TM)
						tm_seq_m = tm_seq_m + 8'd1;
					if (kinds[k] == K_SR)
						sr_seq_m = sr_seq_m + 8'd1;
				end
			end

			// the guard starts before the last byte is on the line.
			if (!timed_out)
				repeat (`HSI_GUARD_TICKS) @(negedge clk);

			if (!timed_out && rx_q.size() != rx_rd)
			begin
				$display("Unexpected bytes on cd_q: %0d more than the frames hold",
					rx_q.size() - rx_rd);
				errors++;
				rx_rd = rx_q.size();
			end
			if (n_ftre - ftre0 != n_sr + n_ccw)
			begin
				$display("Error at %0t: frame_to_reply_end pulses expected %0d, got %0d",
					$time, n_sr + n_ccw, n_ftre - ftre0);
				errors++;
			end
			if ((n_rw0 != rw00) != (n_sr != 0))
			begin
				$display("Error at %0t: reply_wait[0] in guard expected %0d, got %0d",
					$time, n_sr != 0, n_rw0 != rw00);
				errors++;
			end
			if ((n_rw1 != rw10) != (n_ccw != 0))
			begin
				$display("Error at %0t: reply_wait[1] in guard expected %0d, got %0d",
					$time, n_ccw != 0, n_rw1 != rw10);
				errors++;
			end
			// tm_tx_ack spans at least seven byte times of 40 clk cycles each.
			if ((n_tm == 0) ? (n_tm_ack != tma0) :
				(n_tm_ack - tma0 < n_tm * (`HSI_TM_LEN - 1) * 40))
			begin
				$display("Error at %0t: tm_tx_ack high cycles expected %0d or more, got %0d",
					$time, n_tm * (`HSI_TM_LEN - 1) * 40, n_tm_ack - tma0);
				errors++;
			end
			if ((n_sr_ack != sra0) != (n_sr != 0))
			begin
				$display("Error at %0t: sr_tx_ack seen expected %0d, got %0d",
					$time, n_sr != 0, n_sr_ack != sra0);
				errors++;
			end
			// each command-word byte spends at least one byte time in the coder.
			if ((n_ccw == 0) ? (n_ccw_snd != ccs0) :
				(n_ccw_snd - ccs0 < n_ccw * `HSI_CCW_LEN * 40))
			begin
				$display("Error at %0t: ccw_d_sending high cycles expected %0d or more, got %0d",
					$time, n_ccw * `HSI_CCW_LEN * 40, n_ccw_snd - ccs0);
				errors++;
			end

			if (errors != row_err || timed_out)
				failed++;
			$display("row %0d: %s", r, (errors == row_err && !timed_out) ? "pass" : "FAIL");
		end

		errors = errors + frame_errs;
		$display("%0d tests, %0d failed, %0d errors%s", tests, failed, errors,
			timed_out ? ", stopped on a timeout" : "");
		if (errors == 0 && !timed_out)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+include
verilog/hsi_pkg.sv
verilog/hsi_byte_if.sv
verilog/hsi_m_tx_ctrl.sv
verilog/hsi_frame_src.sv
verilog/hsi_btc_src.sv
verilog/hsi_ccw_src.sv
verilog/hsi_crc_unit.sv
verilog/hsi_coder.sv
verilog/hsi_m_tx.sv
test/hsi_m_tx_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only when the run reports success.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module hsi_m_tx_tb -f compile.f

out=$(obj_dir/Vhsi_m_tx_tb)
echo "$out"
echo "$out" | grep -qx "Verification passed"
